//--- design/anti_alias_fir.sv
`timescale 1ns/1ps

module anti_alias_fir (
    input  logic                                 audio_clk,
    input  logic                                 rst_in,
    input  logic                                 in_valid,
    input  logic signed [audio_pkg::SAMPLE_W-1:0] in_data,
    output logic                                 out_valid,
    output logic signed [audio_pkg::SAMPLE_W-1:0] out_data
);

    localparam int TAP_W  = $clog2(audio_pkg::FIR_TAPS);
    localparam int PROD_W = audio_pkg::SAMPLE_W + audio_pkg::COEF_W;
    localparam int ACC_W  = audio_pkg::ACC_W;
    localparam logic [TAP_W-1:0] LAST_TAP = TAP_W'(audio_pkg::FIR_TAPS - 1);

    // Half an output LSB, and the 16-bit limits, at accumulator width.
    localparam logic signed [ACC_W-1:0] ROUND_HALF =
        {{(ACC_W - audio_pkg::COEF_FRAC){1'b0}}, 1'b1, {(audio_pkg::COEF_FRAC - 1){1'b0}}};
    localparam logic signed [ACC_W-1:0] SAT_HI =
        {{(ACC_W - audio_pkg::SAMPLE_W + 1){1'b0}}, {(audio_pkg::SAMPLE_W - 1){1'b1}}};
    localparam logic signed [ACC_W-1:0] SAT_LO =
        {{(ACC_W - audio_pkg::SAMPLE_W + 1){1'b1}}, {(audio_pkg::SAMPLE_W - 1){1'b0}}};

    logic signed [audio_pkg::SAMPLE_W-1:0] delay_line [audio_pkg::FIR_TAPS];
    logic [TAP_W-1:0]                      tap_idx;
    logic                                  mac_busy;
    logic                                  mac_done;
    logic signed [audio_pkg::COEF_W-1:0]   coef_sel;
    logic signed [audio_pkg::SAMPLE_W-1:0] tap_sample;
    logic signed [PROD_W-1:0]              product;
    logic signed [ACC_W-1:0]               product_ext;
    logic signed [ACC_W-1:0]               acc;
    logic signed [ACC_W-1:0]               acc_rounded;
    logic signed [ACC_W-1:0]               acc_shifted;
    logic signed [audio_pkg::SAMPLE_W-1:0] sat_value;

    // ##########################################################
    // Delay line, newest sample at index 0
    // ##########################################################
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            for (int i = 0; i < audio_pkg::FIR_TAPS; i++) begin
                delay_line[i] <= '0;
            end
        end else if (in_valid) begin
            delay_line[0] <= in_data;
            for (int i = 1; i < audio_pkg::FIR_TAPS; i++) begin
                delay_line[i] <= delay_line[i-1];
            end
        end
    end

    // ##########################################################
    // Tap sequencing
    // ##########################################################
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            mac_busy  <= 1'b0;
            tap_idx   <= '0;
            mac_done  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= mac_done;
            mac_done  <= 1'b0;
            if (in_valid) begin
                mac_busy <= 1'b1;
                tap_idx  <= '0;
            end else if (mac_busy) begin
                tap_idx <= tap_idx + 1'b1;
                if (tap_idx == LAST_TAP) begin
                    mac_busy <= 1'b0;
                    mac_done <= 1'b1;  // Sum complete after this edge.
                end
            end
        end
    end

    // One product per clock.
    assign coef_sel    = audio_pkg::FIR_COEFS[tap_idx];
    assign tap_sample  = delay_line[tap_idx];
    assign product     = PROD_W'(coef_sel) * PROD_W'(tap_sample);
    assign product_ext = ACC_W'(product);

    always_ff @(posedge audio_clk) begin
        if (in_valid) begin
            acc <= '0;
        end else if (mac_busy) begin
            acc <= acc + product_ext;
        end
    end

    // Round to nearest, drop the Q15 fraction, clamp to 16 bits.
    assign acc_rounded = acc + ROUND_HALF;
    assign acc_shifted = acc_rounded >>> audio_pkg::COEF_FRAC;

    always_comb begin
        if (acc_shifted > SAT_HI) begin
            sat_value = SAT_HI[audio_pkg::SAMPLE_W-1:0];
        end else if (acc_shifted < SAT_LO) begin
            sat_value = SAT_LO[audio_pkg::SAMPLE_W-1:0];
        end else begin
            sat_value = acc_shifted[audio_pkg::SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge audio_clk) begin
        if (mac_done) begin
            out_data <= sat_value;
        end
    end

endmodule

//--- design/audio_front_end.sv
`timescale 1ns/1ps

module audio_front_end #(
    parameter int OFFSET_LOG2 = 4
) (
    input  logic                                 audio_clk,
    input  logic                                 rst_in,
    input  logic                                 mic_bit,
    input  logic                                 mic_bit_strobe,
    input  logic                                 mic_frame_start,
    input  logic                                 offset_trigger,
    output logic signed [audio_pkg::SAMPLE_W-1:0] raw_audio,
    output logic                                 offset_ready,
    output logic signed [audio_pkg::SAMPLE_W-1:0] offset_value,
    output logic                                 processed_valid,
    output logic signed [audio_pkg::SAMPLE_W-1:0] processed_audio
);

    logic                                  sample_valid;
    logic signed [audio_pkg::SAMPLE_W-1:0] sample_data;

    mic_deserializer deserializer (
        .audio_clk      (audio_clk),
        .rst_in         (rst_in),
        .mic_bit        (mic_bit),
        .mic_bit_strobe (mic_bit_strobe),
        .mic_frame_start(mic_frame_start),
        .sample_valid   (sample_valid),
        .sample_data    (sample_data)
    );

    process_audio #(
        .OFFSET_LOG2(OFFSET_LOG2)
    ) processor (
        .audio_clk             (audio_clk),
        .rst_in                (rst_in),
        .offset_trigger        (offset_trigger),
        .mic_data_valid        (sample_valid),
        .raw_audio_single_cycle(sample_data),
        .raw_audio_in          (raw_audio),
        .offset_ready          (offset_ready),
        .offset_value          (offset_value),
        .processed_valid       (processed_valid),
        .processed_audio       (processed_audio)
    );

endmodule

//--- design/audio_pkg.sv
package audio_pkg;

    // ##########################################################
    // Sample and coefficient formats
    // ##########################################################
    localparam int SAMPLE_W  = 16;  // Two's-complement audio sample.
    localparam int FIR_TAPS  = 15;
    localparam int COEF_W    = 16;  // Signed Q1.15.
    localparam int COEF_FRAC = 15;

    // 32-bit products summed over 15 taps need at most 36 bits.
    localparam int ACC_W = 40;

    // Half-band low-pass, cutoff at fs/4, windowed sinc, DC gain 32768.
    localparam logic signed [COEF_W-1:0] FIR_COEFS [FIR_TAPS] = '{
        -16'sd120,
        16'sd0,
        16'sd532,
        16'sd0,
        -16'sd2248,
        16'sd0,
        16'sd10028,
        16'sd16384,  // Center tap.
        16'sd10028,
        16'sd0,
        -16'sd2248,
        16'sd0,
        16'sd532,
        16'sd0,
        -16'sd120
    };

endpackage

//--- design/mic_deserializer.sv
`timescale 1ns/1ps

module mic_deserializer (
    input  logic                                 audio_clk,
    input  logic                                 rst_in,
    input  logic                                 mic_bit,
    input  logic                                 mic_bit_strobe,
    input  logic                                 mic_frame_start,
    output logic                                 sample_valid,
    output logic signed [audio_pkg::SAMPLE_W-1:0] sample_data
);

    localparam int CNT_W = $clog2(audio_pkg::SAMPLE_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(audio_pkg::SAMPLE_W - 1);

    logic [CNT_W-1:0] bit_count;
    logic             in_frame;
    logic             take_bit;

    // MSB comes with the frame start, later bits only while a frame is open.
    assign take_bit = mic_bit_strobe && (mic_frame_start || in_frame);

    // ##########################################################
    // Frame tracking
    // ##########################################################
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            in_frame     <= 1'b0;
            bit_count    <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            if (mic_bit_strobe) begin
                if (mic_frame_start) begin
                    in_frame  <= 1'b1;
                    bit_count <= CNT_W'(1);  // MSB already taken.
                end else if (in_frame) begin
                    bit_count <= bit_count + 1'b1;
                    if (bit_count == LAST_BIT) begin
                        in_frame     <= 1'b0;
                        sample_valid <= 1'b1;  // Word complete.
                    end
                end
            end
        end
    end

    // Shift register doubles as the output word.
    always_ff @(posedge audio_clk) begin
        if (take_bit) begin
            sample_data <= {sample_data[audio_pkg::SAMPLE_W-2:0], mic_bit};
        end
    end

endmodule

//--- design/offset_estimator.sv
`timescale 1ns/1ps

module offset_estimator #(
    parameter int OFFSET_LOG2 = 4
) (
    input  logic                                 audio_clk,
    input  logic                                 rst_in,
    input  logic                                 sample_strobe,
    input  logic                                 offset_trigger,
    input  logic signed [audio_pkg::SAMPLE_W-1:0] audio_in,
    output logic                                 offset_done,
    output logic signed [audio_pkg::SAMPLE_W-1:0] offset_mean
);

    localparam int SUM_W = audio_pkg::SAMPLE_W + OFFSET_LOG2;
    localparam int CNT_W = OFFSET_LOG2 + 1;
    localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'((1 << OFFSET_LOG2) - 1);

    logic                    busy;
    logic [CNT_W-1:0]        burst_count;
    logic signed [SUM_W-1:0] sum;
    logic signed [SUM_W-1:0] sample_ext;
    logic signed [SUM_W-1:0] next_sum;
    logic signed [SUM_W-1:0] mean_full;

    assign sample_ext = SUM_W'(audio_in);  // Sign extended.
    assign next_sum   = sum + sample_ext;
    assign mean_full  = next_sum >>> OFFSET_LOG2;  // Floor of the mean.

    // ##########################################################
    // Burst control
    // ##########################################################
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            busy        <= 1'b0;
            burst_count <= '0;
            offset_done <= 1'b0;
        end else begin
            offset_done <= 1'b0;
            if (!busy) begin
                if (offset_trigger) begin
                    busy        <= 1'b1;
                    burst_count <= '0;
                end
            end else if (sample_strobe) begin
                burst_count <= burst_count + 1'b1;
                if (burst_count == LAST_COUNT) begin
                    busy        <= 1'b0;
                    offset_done <= 1'b1;
                end
            end
        end
    end

    // Sum and result.
    always_ff @(posedge audio_clk) begin
        if (!busy && offset_trigger) begin
            sum <= '0;
        end else if (busy && sample_strobe) begin
            sum <= next_sum;
            if (burst_count == LAST_COUNT) begin
                offset_mean <= mean_full[audio_pkg::SAMPLE_W-1:0];
            end
        end
    end

endmodule

//--- design/process_audio.sv
`timescale 1ns/1ps

module process_audio #(
    parameter int OFFSET_LOG2 = 4
) (
    input  logic                                 audio_clk,
    input  logic                                 rst_in,
    input  logic                                 offset_trigger,
    input  logic                                 mic_data_valid,
    input  logic signed [audio_pkg::SAMPLE_W-1:0] raw_audio_single_cycle,
    output logic signed [audio_pkg::SAMPLE_W-1:0] raw_audio_in,
    output logic                                 offset_ready,
    output logic signed [audio_pkg::SAMPLE_W-1:0] offset_value,
    output logic                                 processed_valid,
    output logic signed [audio_pkg::SAMPLE_W-1:0] processed_audio
);

    logic                                  fir_in_valid;
    logic signed [audio_pkg::SAMPLE_W-1:0] dc_blocked;
    logic                                  offset_done;
    logic signed [audio_pkg::SAMPLE_W-1:0] offset_mean;
    logic                                  fir_out_valid;
    logic signed [audio_pkg::SAMPLE_W-1:0] fir_out_data;
    logic                                  filt_valid;
    logic signed [audio_pkg::SAMPLE_W-1:0] filt_data;
    logic                                  decim_phase;

    // ##########################################################
    // Raw sample and DC offset
    // ##########################################################
    always_ff @(posedge audio_clk) begin
        if (mic_data_valid) begin
            raw_audio_in <= raw_audio_single_cycle;
        end
    end

    // raw_audio_in is valid one cycle after mic_data_valid.
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            fir_in_valid <= 1'b0;
        end else begin
            fir_in_valid <= mic_data_valid;
        end
    end

    offset_estimator #(
        .OFFSET_LOG2(OFFSET_LOG2)
    ) offset_calculator (
        .audio_clk     (audio_clk),
        .rst_in        (rst_in),
        .sample_strobe (fir_in_valid),
        .offset_trigger(offset_trigger),
        .audio_in      (raw_audio_in),
        .offset_done   (offset_done),
        .offset_mean   (offset_mean)
    );

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            offset_ready <= 1'b0;
        end else if (offset_done) begin
            offset_ready <= 1'b1;  // Sticky until reset.
        end
    end

    always_ff @(posedge audio_clk) begin
        if (offset_done) begin
            offset_value <= offset_mean;
        end
    end

    assign dc_blocked = offset_ready ? (raw_audio_in - offset_value) : raw_audio_in;

    // ##########################################################
    // Anti-alias filter and 2:1 decimation
    // ##########################################################
    anti_alias_fir anti_alias_filter (
        .audio_clk(audio_clk),
        .rst_in   (rst_in),
        .in_valid (fir_in_valid),
        .in_data  (dc_blocked),
        .out_valid(fir_out_valid),
        .out_data (fir_out_data)
    );

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            filt_valid <= 1'b0;
        end else begin
            filt_valid <= fir_out_valid;
        end
    end

    always_ff @(posedge audio_clk) begin
        if (fir_out_valid) begin
            filt_data <= fir_out_data;
        end
    end

    // Phase 0 keeps the output, starting with the first after reset.
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            decim_phase     <= 1'b0;
            processed_valid <= 1'b0;
        end else begin
            processed_valid <= 1'b0;
            if (filt_valid) begin
                decim_phase     <= ~decim_phase;
                processed_valid <= ~decim_phase;
            end
        end
    end

    always_ff @(posedge audio_clk) begin
        if (filt_valid && !decim_phase) begin
            processed_audio <= filt_data;
        end
    end

endmodule

//--- project.f
+incdir+design
design/audio_pkg.sv
design/mic_deserializer.sv
design/offset_estimator.sv
design/anti_alias_fir.sv
design/process_audio.sv
design/audio_front_end.sv
verification/audio_checker.sv
verification/audio_front_end_assert.sv
verification/tb_audio_front_end.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the audio front end testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module tb_audio_front_end \
    -o sim_audio

sim_output=$(./obj_dir/sim_audio)
echo "$sim_output"

if echo "$sim_output" | grep -q "^TEST PASS$"; then
    exit 0
else
    exit 1
fi

//--- verification/audio_checker.sv
`timescale 1ns/1ps

module audio_checker #(
    parameter int OFFSET_LOG2 = 4
) (
    input  logic        audio_clk,
    input  logic        rst_in,
    input  logic        mic_bit,
    input  logic        mic_bit_strobe,
    input  logic        mic_frame_start,
    input  logic        offset_trigger,
    input  logic signed [15:0] raw_audio,
    input  logic        offset_ready,
    input  logic signed [15:0] offset_value,
    input  logic        processed_valid,
    input  logic signed [15:0] processed_audio,
    output int          error_count,
    output int          pending_count
);

    localparam int RAW_LAT  = 2;   // 16th bit strobe to raw_audio.
    localparam int PROC_LAT = 21;  // 16th bit strobe to processed_valid.

    logic signed [15:0] raw_val_q[$];
    longint             raw_time_q[$];
    logic signed [15:0] proc_val_q[$];
    longint             proc_time_q[$];

    longint             cyc = 0;
    logic               rst_prev = 1'b0;  // Reset already applied at the previous edge.
    logic [15:0]        shift_word;
    int                 bit_cnt;
    logic               in_frame = 1'b0;
    logic signed [15:0] dline [audio_pkg::FIR_TAPS];
    int                 fir_count = 0;
    logic               burst_busy = 1'b0;
    int                 burst_n;
    int                 burst_sum;
    longint             trig_cycle;
    logic               have_offset = 1'b0;
    longint             ready_cycle;
    logic signed [15:0] exp_offset;

    initial begin
        error_count = 0;
        for (int i = 0; i < audio_pkg::FIR_TAPS; i++) begin
            dline[i] = '0;
        end
    end

    // Q1.15 dot product, round half up, clamp to 16 bits.
    function automatic logic signed [15:0] fir_output();
        longint acc;
        acc = 0;
        for (int i = 0; i < audio_pkg::FIR_TAPS; i++) begin
            acc += longint'(audio_pkg::FIR_COEFS[i]) * longint'(dline[i]);
        end
        acc = (acc + (longint'(1) <<< (audio_pkg::COEF_FRAC - 1))) >>> audio_pkg::COEF_FRAC;
        if (acc > 32767) begin
            return 16'sd32767;
        end else if (acc < -32768) begin
            return -16'sd32768;
        end
        return 16'(acc);
    endfunction

    // ##########################################################
    // Reference model, one call per received word
    // ##########################################################
    task automatic word_done(input logic signed [15:0] word);
        logic signed [15:0] dc;
        raw_val_q.push_back(word);
        raw_time_q.push_back(cyc + RAW_LAT);
        if (burst_busy && (cyc + 2 > trig_cycle)) begin
            burst_sum += int'(word);
            burst_n++;
            if (burst_n == (1 << OFFSET_LOG2)) begin
                burst_busy  = 1'b0;
                have_offset = 1'b1;
                exp_offset  = 16'(burst_sum >>> OFFSET_LOG2);  // Floor of the mean.
                ready_cycle = cyc + 4;
            end
        end
        if (have_offset && ready_cycle <= cyc + 2) begin
            dc = word - exp_offset;  // Wraps at 16 bits.
        end else begin
            dc = word;
        end
        for (int i = audio_pkg::FIR_TAPS - 1; i > 0; i--) begin
            dline[i] = dline[i-1];
        end
        dline[0] = dc;
        if (fir_count % 2 == 0) begin
            proc_val_q.push_back(fir_output());
            proc_time_q.push_back(cyc + PROC_LAT);
        end
        fir_count++;
    endtask

    always @(posedge audio_clk) begin
        cyc++;
        if (rst_in) begin
            if (rst_prev && processed_valid !== 1'b0) begin
                $display("ERROR t=%0t processed_valid expected 0 got %0b during reset",
                         $time, processed_valid);
                error_count++;
            end
            if (rst_prev && offset_ready !== 1'b0) begin
                $display("ERROR t=%0t offset_ready expected 0 got %0b during reset",
                         $time, offset_ready);
                error_count++;
            end
        end else begin
            if (offset_trigger && !burst_busy) begin
                burst_busy = 1'b1;
                burst_n    = 0;
                burst_sum  = 0;
                trig_cycle = cyc;
            end
            if (mic_bit_strobe) begin
                if (mic_frame_start) begin
                    shift_word = {shift_word[14:0], mic_bit};
                    bit_cnt    = 1;
                    in_frame   = 1'b1;
                end else if (in_frame) begin
                    shift_word = {shift_word[14:0], mic_bit};
                    bit_cnt++;
                    if (bit_cnt == 16) begin
                        in_frame = 1'b0;
                        word_done(shift_word);
                    end
                end
            end

            if (raw_time_q.size() > 0 && raw_time_q[0] == cyc) begin
                if (raw_audio !== raw_val_q[0]) begin
                    $display("ERROR t=%0t raw_audio expected %0d got %0d",
                             $time, raw_val_q[0], raw_audio);
                    error_count++;
                end
                void'(raw_val_q.pop_front());
                void'(raw_time_q.pop_front());
            end

            if (offset_ready !== (have_offset && cyc >= ready_cycle)) begin
                $display("ERROR t=%0t offset_ready expected %0b got %0b",
                         $time, have_offset && cyc >= ready_cycle, offset_ready);
                error_count++;
            end
            if (have_offset && cyc == ready_cycle && offset_value !== exp_offset) begin
                $display("ERROR t=%0t offset_value expected %0d got %0d",
                         $time, exp_offset, offset_value);
                error_count++;
            end

            while (proc_time_q.size() > 0 && proc_time_q[0] < cyc) begin
                $display("t=%0t processed_valid strobe missing, due at cycle %0d",
                         $time, proc_time_q[0]);
                error_count++;
                void'(proc_val_q.pop_front());
                void'(proc_time_q.pop_front());
            end
            if (processed_valid === 1'b1) begin
                if (proc_time_q.size() > 0 && proc_time_q[0] == cyc) begin
                    if (processed_audio !== proc_val_q[0]) begin
                        $display("ERROR t=%0t processed_audio expected %0d got %0d",
                                 $time, proc_val_q[0], processed_audio);
                        error_count++;
                    end
                    void'(proc_val_q.pop_front());
                    void'(proc_time_q.pop_front());
                end else begin
                    $display("t=%0t extra processed_valid strobe with no output due", $time);
                    error_count++;
                end
            end
        end
        rst_prev      = rst_in;
        pending_count = raw_val_q.size() + proc_val_q.size();
    end

endmodule

//--- verification/audio_front_end_assert.sv
`timescale 1ns/1ps

module audio_front_end_assert (
    input logic audio_clk,
    input logic rst_in,
    input logic fir_in_valid,
    input logic fir_out_valid,
    input logic offset_ready
);

    localparam int MIN_GAP = audio_pkg::FIR_TAPS + 3;

    logic [7:0] gap_count;  // Cycles since the last filter input, capped.

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            gap_count <= 8'(MIN_GAP);
        end else if (fir_in_valid) begin
            gap_count <= 8'd1;
        end else if (gap_count < 8'(MIN_GAP)) begin
            gap_count <= gap_count + 8'd1;
        end
    end

    // ##########################################################
    // Filter handshake and offset flag
    // ##########################################################
    assert property (@(posedge audio_clk) disable iff (rst_in)
        fir_in_valid |-> gap_count >= 8'(MIN_GAP))
        else $error("filter input strobes closer than %0d cycles", MIN_GAP);

    assert property (@(posedge audio_clk) disable iff (rst_in)
        fir_out_valid |=> !fir_out_valid)
        else $error("filter out_valid longer than one cycle");

    assert property (@(posedge audio_clk) disable iff (rst_in)
        offset_ready |=> offset_ready)
        else $error("offset_ready fell without reset");

endmodule

bind process_audio audio_front_end_assert assert0 (
    .audio_clk    (audio_clk),
    .rst_in       (rst_in),
    .fir_in_valid (fir_in_valid),
    .fir_out_valid(fir_out_valid),
    .offset_ready (offset_ready)
);

//--- verification/tb_audio_front_end.sv
`timescale 1ns/1ps

module tb_audio_front_end;

    localparam int OFFSET_LOG2   = 4;
    localparam int NUM_SAMPLES   = 300;
    localparam int IDLE_CYCLES   = 8;
    localparam int FRAME_CYCLES  = 16 * 2 + IDLE_CYCLES;
    localparam int TRIGGER_AFTER = 40;
    localparam int MAX_CYCLES    = NUM_SAMPLES * FRAME_CYCLES + 200;
    localparam int DC_BIAS       = 1500;
    localparam int FULL_RUN      = 4;  // Long enough to fill the three center taps.

    logic               audio_clk;
    logic               rst_in;
    logic               mic_bit;
    logic               mic_bit_strobe;
    logic               mic_frame_start;
    logic               offset_trigger;
    logic signed [15:0] raw_audio;
    logic               offset_ready;
    logic signed [15:0] offset_value;
    logic               processed_valid;
    logic signed [15:0] processed_audio;
    int                 error_count;
    int                 pending_count;
    int                 cycle_count = 0;
    logic [31:0]        rng_state = 32'd65;
    int                 full_left = 0;
    logic [15:0]        full_word;

    always #2 audio_clk = ~audio_clk;  // 4 ns period.

    audio_front_end #(
        .OFFSET_LOG2(OFFSET_LOG2)
    ) dut0 (
        .audio_clk      (audio_clk),
        .rst_in         (rst_in),
        .mic_bit        (mic_bit),
        .mic_bit_strobe (mic_bit_strobe),
        .mic_frame_start(mic_frame_start),
        .offset_trigger (offset_trigger),
        .raw_audio      (raw_audio),
        .offset_ready   (offset_ready),
        .offset_value   (offset_value),
        .processed_valid(processed_valid),
        .processed_audio(processed_audio)
    );

    audio_checker #(
        .OFFSET_LOG2(OFFSET_LOG2)
    ) checker0 (
        .audio_clk      (audio_clk),
        .rst_in         (rst_in),
        .mic_bit        (mic_bit),
        .mic_bit_strobe (mic_bit_strobe),
        .mic_frame_start(mic_frame_start),
        .offset_trigger (offset_trigger),
        .raw_audio      (raw_audio),
        .offset_ready   (offset_ready),
        .offset_value   (offset_value),
        .processed_valid(processed_valid),
        .processed_audio(processed_audio),
        .error_count    (error_count),
        .pending_count  (pending_count)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Mostly near the bias, one in eight starts a short run of full-scale words.
    task automatic make_word(output logic [15:0] word);
        rng_state = next_random(rng_state);
        if (full_left > 0) begin
            full_left--;
            word = full_word;
        end else if (rng_state[7:5] == 3'd0) begin
            case (rng_state[9:8])
                2'd0:    full_word = 16'h7fff;
                2'd1:    full_word = 16'h8000;
                default: full_word = rng_state[31:16];
            endcase
            full_left = FULL_RUN - 1;
            word      = full_word;
        end else begin
            word = 16'(DC_BIAS + int'(rng_state[20:12]) - 256);
        end
    endtask

    // ##########################################################
    // Serial frame, MSB first, strobe every second cycle
    // ##########################################################
    task automatic send_frame(input logic [15:0] word, input int sample_idx);
        for (int i = 15; i >= 0; i--) begin
            @(posedge audio_clk);
            mic_bit         <= word[i];
            mic_bit_strobe  <= 1'b1;
            mic_frame_start <= (i == 15);
            @(posedge audio_clk);
            mic_bit_strobe  <= 1'b0;
            mic_frame_start <= 1'b0;
        end
        for (int g = 0; g < IDLE_CYCLES; g++) begin
            @(posedge audio_clk);
            offset_trigger <= (sample_idx == TRIGGER_AFTER - 1) && (g == 2);
        end
    endtask

    always @(posedge audio_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        logic [15:0] word;
        audio_clk       = 1'b0;
        rst_in          = 1'b1;
        mic_bit         = 1'b0;
        mic_bit_strobe  = 1'b0;
        mic_frame_start = 1'b0;
        offset_trigger  = 1'b0;
        repeat (2) @(posedge audio_clk);
        rst_in <= 1'b0;
        for (int n = 0; n < NUM_SAMPLES; n++) begin
            make_word(word);
            send_frame(word, n);
        end
        while (pending_count != 0) begin
            @(negedge audio_clk);  // Drain the last expected outputs.
        end
        repeat (4) @(negedge audio_clk);
        $display("Run finished: %0d errors, %0d outputs outstanding",
                 error_count, pending_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
